/* Bender.yml */
package:
  name: fetch_queue

sources:
  - fq_cfg_pkg.sv
  - fq_isa_pkg.sv
  - simple_dual_port_ram.sv
  - sync_fifo.sv
  - fq_ingress.sv
  - fq_predecode.sv
  - fq_issue.sv
  - fetch_queue.sv
  - target: test
    files:
      - fq_checker.sv
      - tb_fetch_queue.sv

/* fetch_queue.sv */
// fetch queue top level
// ingress register, fall-through FIFO, head predecode and credit-based issue
`timescale 1ns/1ps

module fetch_queue (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush_i,
  input  logic                              fetch_valid_i,
  input  logic [fq_cfg_pkg::FQ_PC_W-1:0]    fetch_pc_i,
  input  logic [fq_cfg_pkg::FQ_INSTR_W-1:0] fetch_instr_i,
  output logic                              fetch_credit_o,
  input  logic                              issue_credit_i,
  output logic                              issue_valid_o,
  output logic [fq_cfg_pkg::FQ_PC_W-1:0]    issue_pc_o,
  output fq_isa_pkg::iclass_e               issue_class_o,
  output logic [fq_isa_pkg::REG_ADDR_W-1:0] issue_rd_o,
  output logic [fq_isa_pkg::REG_ADDR_W-1:0] issue_rs1_o,
  output logic [fq_cfg_pkg::FQ_INSTR_W-1:0] issue_operand_o
);

  import fq_cfg_pkg::*;
  import fq_isa_pkg::*;

  // ingress to fifo
  logic                  push;
  logic [FQ_ENTRY_W-1:0] entry;
  // fifo head
  logic [FQ_ENTRY_W-1:0] head;
  logic                  empty;
  logic                  pop;
  // predecoded head
  logic [FQ_PC_W-1:0]    pd_pc;
  iclass_e               pd_class;
  logic [REG_ADDR_W-1:0] pd_rd;
  logic [REG_ADDR_W-1:0] pd_rs1;
  logic [FQ_INSTR_W-1:0] pd_operand;

  fq_ingress u_ingress (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_pc_i     (fetch_pc_i),
    .fetch_instr_i  (fetch_instr_i),
    .pop_i          (pop),
    .push_o         (push),
    .entry_o        (entry),
    .fetch_credit_o (fetch_credit_o)
  );

  // full and usage stay open, the credit loop bounds occupancy
  sync_fifo #(
    .DEPTH (FQ_DEPTH),
    .WIDTH (FQ_ENTRY_W)
  ) u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .push_i  (push),
    .pop_i   (pop),
    .data_i  (entry),
    .data_o  (head),
    .empty_o (empty),
    .full_o  (),
    .usage_o ()
  );

  fq_predecode u_predecode (
    .entry_i   (head),
    .pc_o      (pd_pc),
    .class_o   (pd_class),
    .rd_o      (pd_rd),
    .rs1_o     (pd_rs1),
    .operand_o (pd_operand)
  );

  fq_issue u_issue (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush_i         (flush_i),
    .empty_i         (empty),
    .issue_credit_i  (issue_credit_i),
    .pc_i            (pd_pc),
    .class_i         (pd_class),
    .rd_i            (pd_rd),
    .rs1_i           (pd_rs1),
    .operand_i       (pd_operand),
    .pop_o           (pop),
    .issue_valid_o   (issue_valid_o),
    .issue_pc_o      (issue_pc_o),
    .issue_class_o   (issue_class_o),
    .issue_rd_o      (issue_rd_o),
    .issue_rs1_o     (issue_rs1_o),
    .issue_operand_o (issue_operand_o)
  );

endmodule

/* fq_cfg_pkg.sv */
// sizing constants for the fetch queue
// shared by the FIFO, the credit logic and the testbench
package fq_cfg_pkg;

  // ===================
  // queue storage
  // ===================
  // entries in the FIFO, also the upstream credit pool
  localparam int unsigned FQ_DEPTH = 8;
  // pointer and occupancy widths
  localparam int unsigned FQ_ADDR_W = $clog2(FQ_DEPTH);
  localparam int unsigned FQ_CNT_W  = $clog2(FQ_DEPTH + 1);

  // entry layout, pc on top, instruction below
  localparam int unsigned FQ_PC_W    = 32;
  localparam int unsigned FQ_INSTR_W = 32;
  localparam int unsigned FQ_ENTRY_W = FQ_PC_W + FQ_INSTR_W;

  // ===================
  // issue side
  // ===================
  // credits held toward decode after reset
  localparam int unsigned FQ_ISSUE_CREDITS = 4;
  localparam int unsigned FQ_ISSUE_CNT_W   = $clog2(FQ_ISSUE_CREDITS + 1);

endpackage

/* fq_checker.sv */
// scoreboard for the fetch queue testbench
// queues each accepted fetch with its expected predecode fields,
// compares issued records in order and models both credit pools
`timescale 1ns/1ps

module fq_checker (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush_i,
  input  logic                              fetch_valid_i,
  input  logic [fq_cfg_pkg::FQ_PC_W-1:0]    fetch_pc_i,
  input  logic                              fetch_credit_i,
  input  logic                              issue_credit_i,
  input  logic                              issue_valid_i,
  input  logic [fq_cfg_pkg::FQ_PC_W-1:0]    issue_pc_i,
  input  logic [1:0]                        issue_class_i,
  input  logic [4:0]                        issue_rd_i,
  input  logic [4:0]                        issue_rs1_i,
  input  logic [31:0]                       issue_operand_i,
  input  logic [1:0]                        exp_class_i,
  input  logic [4:0]                        exp_rd_i,
  input  logic [4:0]                        exp_rs1_i,
  input  logic [31:0]                       exp_operand_i,
  input  int                                exp_lat_i,
  input  logic                              test_done_i,
  input  logic [8*16-1:0]                   test_name_i,
  output int                                pending_o,
  output int                                errors_o,
  output int                                tests_o,
  output int                                failed_tests_o
);

  import fq_cfg_pkg::*;

  // expected records, oldest first
  logic [31:0] q_pc [$];
  logic [1:0]  q_class [$];
  logic [4:0]  q_rd [$];
  logic [4:0]  q_rs1 [$];
  logic [31:0] q_op [$];
  int          q_lat [$];
  int          q_cyc [$];

  int cyc = 0;
  int dcred = FQ_ISSUE_CREDITS;
  int ucred = FQ_DEPTH;
  int test_err_base = 0;

  initial begin
    pending_o = 0;
    errors_o = 0;
    tests_o = 0;
    failed_tests_o = 0;
  end

  task automatic compare(input string field, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %0s %0s expected %h actual %h", test_name_i, field, exp, act);
      errors_o++;
    end
  endtask

  task automatic complain(input string what);
    $display("test %0s: %0s", test_name_i, what);
    errors_o++;
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      cyc++;
      // ====================
      // issued records
      // ====================
      if (issue_valid_i) begin
        if (q_pc.size() == 0) begin
          complain("item issued that was never pushed or was flushed");
        end else begin
          compare("pc", q_pc.pop_front(), issue_pc_i);
          compare("class", q_class.pop_front(), issue_class_i);
          compare("rd", q_rd.pop_front(), issue_rd_i);
          compare("rs1", q_rs1.pop_front(), issue_rs1_i);
          compare("operand", q_op.pop_front(), issue_operand_i);
          // zero latency means unchecked
          if (q_lat[0] != 0) begin
            compare("latency", q_lat[0], cyc - q_cyc[0]);
          end
          void'(q_lat.pop_front());
          void'(q_cyc.pop_front());
        end
        dcred--;
        if (dcred < 0) begin
          complain("item issued without a downstream credit");
        end
      end
      // ====================
      // credit models
      // ====================
      if (issue_credit_i) begin
        dcred++;
        if (dcred > FQ_ISSUE_CREDITS) begin
          complain("downstream credits above initial count");
        end
      end
      if (flush_i) begin
        // flushed items never issue
        q_pc.delete();
        q_class.delete();
        q_rd.delete();
        q_rs1.delete();
        q_op.delete();
        q_lat.delete();
        q_cyc.delete();
        ucred = FQ_DEPTH;
      end else begin
        ucred = ucred + fetch_credit_i - fetch_valid_i;
        if (ucred < 0 || ucred > FQ_DEPTH) begin
          complain("upstream credit count out of range");
        end
      end
      if (fetch_valid_i && !flush_i) begin
        q_pc.push_back(fetch_pc_i);
        q_class.push_back(exp_class_i);
        q_rd.push_back(exp_rd_i);
        q_rs1.push_back(exp_rs1_i);
        q_op.push_back(exp_operand_i);
        q_lat.push_back(exp_lat_i);
        q_cyc.push_back(cyc);
      end
      // ====================
      // end of one test
      // ====================
      if (test_done_i) begin
        if (q_pc.size() != 0) begin
          complain("pushed items were lost");
        end
        if (ucred != FQ_DEPTH) begin
          complain("not all upstream credits came back");
        end
        tests_o++;
        if (errors_o != test_err_base) begin
          failed_tests_o++;
        end
        $display("test %0s: %0s, %0d errors", test_name_i,
                 (errors_o == test_err_base) ? "passed" : "failed", errors_o - test_err_base);
        test_err_base = errors_o;
      end
      pending_o = q_pc.size();
    end
  end

endmodule

/* fq_ingress.sv */
// input register stage of the fetch queue
// registers each accepted fetch into one entry and returns upstream credits on pops
`timescale 1ns/1ps

module fq_ingress (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush_i,
  input  logic                              fetch_valid_i,
  input  logic [fq_cfg_pkg::FQ_PC_W-1:0]    fetch_pc_i,
  input  logic [fq_cfg_pkg::FQ_INSTR_W-1:0] fetch_instr_i,
  input  logic                              pop_i,
  output logic                              push_o,
  output logic [fq_cfg_pkg::FQ_ENTRY_W-1:0] entry_o,
  output logic                              fetch_credit_o
);

  import fq_cfg_pkg::*;

  // mirror of the credits still held by the fetch unit
  logic [FQ_CNT_W-1:0] prod_cnt_q;

  // control, flush drops the staged word and any pending credit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_o         <= 1'b0;
      fetch_credit_o <= 1'b0;
    end else if (flush_i) begin
      push_o         <= 1'b0;
      fetch_credit_o <= 1'b0;
    end else begin
      push_o         <= fetch_valid_i;
      fetch_credit_o <= pop_i;
    end
  end

  // payload, pc in the upper half
  always_ff @(posedge clk) begin
    if (fetch_valid_i) begin
      entry_o <= {fetch_pc_i, fetch_instr_i};
    end
  end

  // producer spends on fetch, regains on each credit pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_cnt_q <= FQ_CNT_W'(FQ_DEPTH);
    end else if (flush_i) begin
      prod_cnt_q <= FQ_CNT_W'(FQ_DEPTH);
    end else if (fetch_credit_o && !fetch_valid_i) begin
      prod_cnt_q <= prod_cnt_q + 1'b1;
    end else if (fetch_valid_i && !fetch_credit_o) begin
      prod_cnt_q <= prod_cnt_q - 1'b1;
    end
  end

  // credit loop closes through the FIFO and the issue stage
  a_prod_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    prod_cnt_q <= FQ_CNT_W'(FQ_DEPTH))
    else $error("upstream credits above queue depth");

endmodule

/* fq_isa_pkg.sv */
// instruction word views and predecode encodings
// only the register-register and register-immediate formats are covered
package fq_isa_pkg;

  // register specifier width
  localparam int unsigned REG_ADDR_W = 5;

  // major opcodes recognised by predecode
  localparam logic [6:0] OPC_REG = 7'h33;
  localparam logic [6:0] OPC_IMM = 7'h13;

  // register-register layout
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  // register-immediate layout, imm12 overlays funct7 and rs2
  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  // one 32-bit word, two readings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

  // predecode class handed to decode
  typedef enum logic [1:0] {
    CLS_REG     = 2'd0,
    CLS_IMM     = 2'd1,
    CLS_ILLEGAL = 2'd2
  } iclass_e;

endpackage

/* fq_issue.sv */
// issue stage of the fetch queue
// pops the FIFO head while decode has credits and registers the predecoded record
`timescale 1ns/1ps

module fq_issue (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush_i,
  input  logic                              empty_i,
  input  logic                              issue_credit_i,
  input  logic [fq_cfg_pkg::FQ_PC_W-1:0]    pc_i,
  input  fq_isa_pkg::iclass_e               class_i,
  input  logic [fq_isa_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic [fq_isa_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [fq_cfg_pkg::FQ_INSTR_W-1:0] operand_i,
  output logic                              pop_o,
  output logic                              issue_valid_o,
  output logic [fq_cfg_pkg::FQ_PC_W-1:0]    issue_pc_o,
  output fq_isa_pkg::iclass_e               issue_class_o,
  output logic [fq_isa_pkg::REG_ADDR_W-1:0] issue_rd_o,
  output logic [fq_isa_pkg::REG_ADDR_W-1:0] issue_rs1_o,
  output logic [fq_cfg_pkg::FQ_INSTR_W-1:0] issue_operand_o
);

  import fq_cfg_pkg::*;

  logic [FQ_ISSUE_CNT_W-1:0] credit_q;

  // send when a head exists and decode has room
  // no pop in a flush cycle, the head is being discarded
  assign pop_o = !empty_i && (credit_q != '0) && !flush_i;

  // flush leaves credits alone, decode still holds its items
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= FQ_ISSUE_CNT_W'(FQ_ISSUE_CREDITS);
    end else if (issue_credit_i && !pop_o) begin
      credit_q <= credit_q + 1'b1;
    end else if (pop_o && !issue_credit_i) begin
      credit_q <= credit_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= pop_o;
    end
  end

  // record fields, only loaded on a pop
  always_ff @(posedge clk) begin
    if (pop_o) begin
      issue_pc_o      <= pc_i;
      issue_class_o   <= class_i;
      issue_rd_o      <= rd_i;
      issue_rs1_o     <= rs1_i;
      issue_operand_o <= operand_i;
    end
  end

  // consumer returns no more than it was given
  a_issue_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credit_q <= FQ_ISSUE_CNT_W'(FQ_ISSUE_CREDITS))
    else $error("issue credits above initial count");

endmodule

/* fq_predecode.sv */
// combinational predecode of the FIFO head
// splits the entry into pc and instruction and extracts the issue fields
// any opcode other than reg-reg or reg-imm is issued as illegal
`timescale 1ns/1ps

module fq_predecode (
  input  logic [fq_cfg_pkg::FQ_ENTRY_W-1:0] entry_i,
  output logic [fq_cfg_pkg::FQ_PC_W-1:0]    pc_o,
  output fq_isa_pkg::iclass_e               class_o,
  output logic [fq_isa_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [fq_isa_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [fq_cfg_pkg::FQ_INSTR_W-1:0] operand_o
);

  import fq_cfg_pkg::*;
  import fq_isa_pkg::*;

  instr_u instr;

  // upper half pc, lower half instruction word
  assign pc_o  = entry_i[FQ_ENTRY_W-1 -: FQ_PC_W];
  assign instr = entry_i[FQ_INSTR_W-1:0];

  always_comb begin
    // illegal by default, all fields zero
    class_o   = CLS_ILLEGAL;
    rd_o      = '0;
    rs1_o     = '0;
    operand_o = '0;
    // opcode sits in the same bits for both views
    case (instr.r_fmt.opcode)
      OPC_REG: begin
        class_o   = CLS_REG;
        rd_o      = instr.r_fmt.rd;
        rs1_o     = instr.r_fmt.rs1;
        // rs2 zero-extended
        operand_o = {{(FQ_INSTR_W - REG_ADDR_W){1'b0}}, instr.r_fmt.rs2};
      end
      OPC_IMM: begin
        class_o   = CLS_IMM;
        rd_o      = instr.i_fmt.rd;
        rs1_o     = instr.i_fmt.rs1;
        // imm12 sign-extended
        operand_o = {{(FQ_INSTR_W - 12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
      end
      default: begin
        class_o = CLS_ILLEGAL;
      end
    endcase
  end

endmodule

/* fq_vectors.txt */
# P pc instr class rd rs1 operand latency (hex; class 0 reg 1 imm 2 illegal; latency 0 unchecked)
# T name starts a test, F flush, C n returns n issue credits, W n idles n cycles
T latency
W 4
P 00001000 002081b3 0 03 01 00000002 2
W 4
P 00001004 00558513 1 0a 0b 00000005 2
W 4
C 2
T predecode_bp
P 00002000 407302b3 0 05 06 00000007 0
P 00002004 fff10093 1 01 02 ffffffff 0
P 00002008 80020213 1 04 04 fffff800 0
P 0000200c 00012083 2 00 00 00000000 0
P 00002010 ffffffff 2 00 00 00000000 0
P 00002014 01df6fb3 0 1f 1e 0000001d 0
P 00002018 7ff47393 1 07 08 000007ff 0
W 4
P 0000201c 002081b3 0 03 01 00000002 0
P 00002020 00558513 1 0a 0b 00000005 0
P 00002024 01df6fb3 0 1f 1e 0000001d 0
P 00002028 fff10093 1 01 02 ffffffff 0
P 0000202c 00000000 2 00 00 00000000 0
W 4
C 12
T flush
P 00003000 002081b3 0 03 01 00000002 0
P 00003004 00558513 1 0a 0b 00000005 0
P 00003008 407302b3 0 05 06 00000007 0
P 0000300c 80020213 1 04 04 fffff800 0
W 4
P 00003010 fff10093 1 01 02 ffffffff 0
P 00003014 7ff47393 1 07 08 000007ff 0
W 2
F
C 4
W 2
P 00003100 01df6fb3 0 1f 1e 0000001d 0
W 4
C 1

/* sim.f */
fq_cfg_pkg.sv
fq_isa_pkg.sv
simple_dual_port_ram.sv
sync_fifo.sv
fq_ingress.sv
fq_predecode.sv
fq_issue.sv
fetch_queue.sv
fq_checker.sv
tb_fetch_queue.sv

/* simple_dual_port_ram.sv */
// storage array behind the FIFO
// one synchronous write port, one asynchronous read port
`timescale 1ns/1ps

module simple_dual_port_ram #(
  parameter int unsigned DEPTH = fq_cfg_pkg::FQ_DEPTH,
  parameter int unsigned WIDTH = fq_cfg_pkg::FQ_ENTRY_W,
  localparam int unsigned ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic              clk,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] waddr_i,
  input  logic [WIDTH-1:0]  wdata_i,
  input  logic [ADDR_W-1:0] raddr_i,
  output logic [WIDTH-1:0]  rdata_o
);

  // plain register array
  logic [WIDTH-1:0] mem [DEPTH];

  // write on the clock edge
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // read straight through, head visible in the same cycle
  assign rdata_o = mem[raddr_i];

endmodule

/* sync_fifo.sv */
// single-clock first-word-fall-through FIFO with synchronous flush
// an empty FIFO passes a push straight to data_o so the head never lags a cycle
`timescale 1ns/1ps

module sync_fifo #(
  parameter int unsigned DEPTH = fq_cfg_pkg::FQ_DEPTH,
  parameter int unsigned WIDTH = fq_cfg_pkg::FQ_ENTRY_W,
  localparam int unsigned ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int unsigned CNT_W  = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o,
  output logic [CNT_W-1:0] usage_o
);

  logic [ADDR_W-1:0] rd_ptr_q, rd_ptr_d;
  logic [ADDR_W-1:0] wr_ptr_q, wr_ptr_d;
  logic [CNT_W-1:0]  cnt_q, cnt_d;
  logic [WIDTH-1:0]  ram_rdata;
  logic              do_push, do_pop, bypass;

  simple_dual_port_ram #(
    .DEPTH (DEPTH),
    .WIDTH (WIDTH)
  ) u_ram (
    .clk     (clk),
    .we_i    (do_push),
    .waddr_i (wr_ptr_q),
    .wdata_i (data_i),
    .raddr_i (rd_ptr_q),
    .rdata_o (ram_rdata)
  );

  // ===================
  // status
  // ===================
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  // a push into an empty FIFO already counts as a head
  assign empty_o = (cnt_q == '0) && !push_i;
  assign usage_o = cnt_q;
  // word goes straight out and never lands in the array
  assign bypass  = (cnt_q == '0) && push_i && pop_i;
  assign data_o  = (cnt_q == '0) ? data_i : ram_rdata;

  assign do_push = push_i && !full_o && !bypass;
  assign do_pop  = pop_i && !empty_o && !bypass;

  // ===================
  // pointer update
  // ===================
  always_comb begin
    wr_ptr_d = wr_ptr_q;
    rd_ptr_d = rd_ptr_q;
    cnt_d    = cnt_q;
    // explicit wrap, needed when DEPTH is not a power of two
    if (do_push) begin
      wr_ptr_d = (wr_ptr_q == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
    end
    if (do_pop) begin
      rd_ptr_d = (rd_ptr_q == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
    end
    // push and pop together leave the count alone
    if (do_push && !do_pop) begin
      cnt_d = cnt_q + 1'b1;
    end else if (do_pop && !do_push) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_d;
      rd_ptr_q <= rd_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  // callers must respect the flags
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full_o)
    else $error("fifo overflow");
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o)
    else $error("fifo underflow");

endmodule

/* tb_fetch_queue.sv */
// testbench for the fetch queue
// reads commands from the vector file and drives them into the DUT,
// modelling the upstream credit counter; fq_checker does the comparing
`timescale 1ns/1ps

module tb_fetch_queue;

  import fq_cfg_pkg::*;

  localparam int TIMEOUT = 500;

  logic        clk;
  logic        rst_n;
  logic        flush_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_pc_i;
  logic [31:0] fetch_instr_i;
  logic        fetch_credit_o;
  logic        issue_credit_i;
  logic        issue_valid_o;
  logic [31:0] issue_pc_o;
  logic [1:0]  issue_class_o;
  logic [4:0]  issue_rd_o;
  logic [4:0]  issue_rs1_o;
  logic [31:0] issue_operand_o;

  // expected fields travel with each push
  logic [1:0]  exp_class;
  logic [4:0]  exp_rd;
  logic [4:0]  exp_rs1;
  logic [31:0] exp_operand;
  int          exp_lat;
  logic        test_done;
  logic [8*16-1:0] test_name;
  int pending, errors, tests, failed_tests;

  int avail;
  logic [31:0] seed = 32'h6ae1_1142;
  // set when a credit wait runs out, ends the run
  bit timed_out = 1'b0;
  // vector file missing or malformed
  bit file_bad = 1'b0;

  fetch_queue fetch_queue_i (
    .clk (clk), .rst_n (rst_n), .flush_i (flush_i),
    .fetch_valid_i (fetch_valid_i), .fetch_pc_i (fetch_pc_i),
    .fetch_instr_i (fetch_instr_i), .fetch_credit_o (fetch_credit_o),
    .issue_credit_i (issue_credit_i), .issue_valid_o (issue_valid_o),
    .issue_pc_o (issue_pc_o), .issue_class_o (issue_class_o),
    .issue_rd_o (issue_rd_o), .issue_rs1_o (issue_rs1_o),
    .issue_operand_o (issue_operand_o)
  );

  fq_checker checker_i (
    .clk (clk), .rst_n (rst_n), .flush_i (flush_i),
    .fetch_valid_i (fetch_valid_i), .fetch_pc_i (fetch_pc_i),
    .fetch_credit_i (fetch_credit_o), .issue_credit_i (issue_credit_i),
    .issue_valid_i (issue_valid_o), .issue_pc_i (issue_pc_o),
    .issue_class_i (issue_class_o), .issue_rd_i (issue_rd_o),
    .issue_rs1_i (issue_rs1_o), .issue_operand_i (issue_operand_o),
    .exp_class_i (exp_class), .exp_rd_i (exp_rd), .exp_rs1_i (exp_rs1),
    .exp_operand_i (exp_operand), .exp_lat_i (exp_lat),
    .test_done_i (test_done), .test_name_i (test_name),
    .pending_o (pending), .errors_o (errors), .tests_o (tests),
    .failed_tests_o (failed_tests)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fetch unit credits, restored on flush
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      avail <= FQ_DEPTH;
    end else if (flush_i) begin
      avail <= FQ_DEPTH;
    end else begin
      avail <= avail + fetch_credit_o - fetch_valid_i;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic push_item(input logic [31:0] pc, input logic [31:0] instr,
                           input logic [1:0] cls, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [31:0] op, input int lat);
    int n;
    n = 0;
    while (avail == 0 && !timed_out) begin
      step();
      n++;
      if (n > TIMEOUT) begin
        $display("timeout while waiting for an upstream credit");
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      // random idle gap of 0 to 2 cycles
      seed = lcg_next(seed);
      repeat (seed[17:16] % 3) step();
      fetch_valid_i = 1'b1;
      fetch_pc_i = pc;
      fetch_instr_i = instr;
      exp_class = cls;
      exp_rd = rd;
      exp_rs1 = rs1;
      exp_operand = op;
      exp_lat = lat;
      step();
      fetch_valid_i = 1'b0;
    end
  endtask

  // queue drained and all upstream credits home, or given up after TIMEOUT cycles
  // the checker then reports whatever is still missing
  task automatic close_test();
    int n;
    n = 0;
    while ((pending != 0 || avail != FQ_DEPTH) && n <= TIMEOUT) begin
      step();
      n++;
    end
    test_done = 1'b1;
    step();
    test_done = 1'b0;
  endtask

  initial begin
    int fd, r, n, lat;
    string line;
    logic [7:0] cmd;
    logic [31:0] pc, instr, op;
    logic [1:0] cls;
    logic [4:0] rd, rs1;
    bit open;
    rst_n = 1'b0;
    flush_i = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_pc_i = '0;
    fetch_instr_i = '0;
    issue_credit_i = 1'b0;
    exp_class = '0;
    exp_rd = '0;
    exp_rs1 = '0;
    exp_operand = '0;
    exp_lat = 0;
    test_done = 1'b0;
    test_name = "none";
    open = 0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    step();
    fd = $fopen("fq_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      file_bad = 1'b1;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        r = $fgets(line, fd);
        cmd = "#";
        r = $sscanf(line, "%c", cmd);
        case (cmd)
          "T": begin
            if (open) close_test();
            r = $sscanf(line, "T %s", test_name);
            open = 1;
          end
          "P": begin
            r = $sscanf(line, "P %h %h %d %h %h %h %d", pc, instr, cls, rd, rs1, op, lat);
            if (r == 7) begin
              push_item(pc, instr, cls, rd, rs1, op, lat);
            end else begin
              $display("malformed push line in the vector file");
              file_bad = 1'b1;
            end
          end
          "F": begin
            flush_i = 1'b1;
            step();
            flush_i = 1'b0;
          end
          "C": begin
            r = $sscanf(line, "C %d", n);
            issue_credit_i = 1'b1;
            repeat (n) step();
            issue_credit_i = 1'b0;
          end
          "W": begin
            r = $sscanf(line, "W %d", n);
            repeat (n) step();
          end
          default: ;
        endcase
      end
      $fclose(fd);
      if (open && !timed_out) close_test();
    end
    step();
    $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
    if (!file_bad && !timed_out && errors == 0 && tests > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
